//--- sim.f
+incdir+hdl
+incdir+tests
hdl/csr_pkg.sv
hdl/csr_issue.sv
hdl/csr_file.sv
hdl/csr_timer.sv
hdl/csr_top.sv
tests/csr_tb.sv

//--- tests/csr_vectors.svh
`ifndef CSR_VECTORS_SVH
`define CSR_VECTORS_SVH

localparam int NUM_ROWS = 55;

// op, arg, din, mask, pc, badv, hw_int, ipi, timer wait (0 for a plain row)
// din of SAVE writes and of exchanges is replaced with random data
vec_t rows [NUM_ROWS] = '{
    // reset values
    '{CSRRD,   `CSR_CRMD,   0, 0, 32'h1c000000, 0, 0, 0, 0},
    '{CSRRD,   `CSR_PRMD,   0, 0, 32'h1c000004, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ECFG,   0, 0, 32'h1c000008, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ESTAT,  0, 0, 32'h1c00000c, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ERA,    0, 0, 32'h1c000010, 0, 0, 0, 0},
    '{CSRRD,   `CSR_BADV,   0, 0, 32'h1c000014, 0, 0, 0, 0},
    '{CSRRD,   `CSR_EENTRY, 0, 0, 32'h1c000018, 0, 0, 0, 0},
    '{CSRRD,   `CSR_SAVE0,  0, 0, 32'h1c00001c, 0, 0, 0, 0},
    '{CSRRD,   `CSR_SAVE3,  0, 0, 32'h1c000020, 0, 0, 0, 0},
    '{CSRRD,   `CSR_TID,    0, 0, 32'h1c000024, 0, 0, 0, 0},
    '{CSRRD,   `CSR_TCFG,   0, 0, 32'h1c000028, 0, 0, 0, 0},
    // plain writes and read-back
    '{CSRWR,   `CSR_SAVE0,  0, 0, 32'h1c00002c, 0, 0, 0, 0},
    '{CSRWR,   `CSR_SAVE1,  0, 0, 32'h1c000030, 0, 0, 0, 0},
    '{CSRWR,   `CSR_SAVE2,  0, 0, 32'h1c000034, 0, 0, 0, 0},
    '{CSRWR,   `CSR_SAVE3,  0, 0, 32'h1c000038, 0, 0, 0, 0},
    '{CSRWR,   `CSR_TID,    32'h00000a5c, 0, 32'h1c00003c, 0, 0, 0, 0},
    '{CSRWR,   `CSR_EENTRY, 32'h1c00807f, 0, 32'h1c000040, 0, 0, 0, 0},
    '{CSRRD,   `CSR_SAVE0,  0, 0, 32'h1c000044, 0, 0, 0, 0},
    '{CSRRD,   `CSR_SAVE3,  0, 0, 32'h1c000048, 0, 0, 0, 0},
    '{CSRRD,   `CSR_TID,    0, 0, 32'h1c00004c, 0, 0, 0, 0},
    '{CSRRD,   `CSR_EENTRY, 0, 0, 32'h1c000050, 0, 0, 0, 0},
    // masked exchange
    '{CSRXCHG, `CSR_SAVE1,  0, 32'h0000ffff, 32'h1c000054, 0, 0, 0, 0},
    '{CSRXCHG, `CSR_SAVE2,  0, 32'hf0f00f0f, 32'h1c000058, 0, 0, 0, 0},
    '{CSRRD,   `CSR_SAVE1,  0, 0, 32'h1c00005c, 0, 0, 0, 0},
    '{CSRRD,   `CSR_SAVE2,  0, 0, 32'h1c000060, 0, 0, 0, 0},
    // da and pg both set, so the pair keeps its old value
    '{CSRWR,   `CSR_CRMD,   32'h0000001b, 0, 32'h1c000064, 0, 0, 0, 0},
    '{CSRRD,   `CSR_CRMD,   0, 0, 32'h1c000068, 0, 0, 0, 0},
    // fetch address error, badv from pc
    '{EXCP,    16'h0008,    0, 0, 32'h1c000200, 32'hdeadbeef, 0, 0, 0},
    '{CSRRD,   `CSR_ERA,    0, 0, 32'h1c000204, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ESTAT,  0, 0, 32'h1c000208, 0, 0, 0, 0},
    '{CSRRD,   `CSR_PRMD,   0, 0, 32'h1c00020c, 0, 0, 0, 0},
    '{CSRRD,   `CSR_CRMD,   0, 0, 32'h1c000210, 0, 0, 0, 0},
    '{CSRRD,   `CSR_BADV,   0, 0, 32'h1c000214, 0, 0, 0, 0},
    '{ERTN,    16'h0000,    0, 0, 32'h1c000218, 0, 0, 0, 0},
    '{CSRRD,   `CSR_CRMD,   0, 0, 32'h1c00021c, 0, 0, 0, 0},
    // memory address error keeps the reported badv
    '{EXCP,    16'h0048,    0, 0, 32'h1c000300, 32'h00c0ffee, 0, 0, 0},
    '{CSRRD,   `CSR_BADV,   0, 0, 32'h1c000304, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ESTAT,  0, 0, 32'h1c000308, 0, 0, 0, 0},
    '{ERTN,    16'h0000,    0, 0, 32'h1c00030c, 0, 0, 0, 0},
    // hardware line 0, first masked by CRMD.IE
    '{CSRWR,   `CSR_ECFG,   32'h00000004, 0, 32'h1c000400, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ESTAT,  0, 0, 32'h1c000404, 0, 8'h01, 1, 0},
    '{CSRWR,   `CSR_CRMD,   32'h0000000c, 0, 32'h1c000408, 0, 8'h01, 0, 0},
    '{CSRRD,   `CSR_SAVE0,  0, 0, 32'h1c00040c, 0, 8'h01, 0, 0},
    '{CSRRD,   `CSR_ESTAT,  0, 0, 32'h1c000410, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ERA,    0, 0, 32'h1c000414, 0, 0, 0, 0},
    '{ERTN,    16'h0000,    0, 0, 32'h1c000418, 0, 0, 0, 0},
    // periodic timer, initial value 0x10
    '{CSRWR,   `CSR_ECFG,   32'h00000800, 0, 32'h1c000500, 0, 0, 0, 0},
    '{CSRWR,   `CSR_TCFG,   32'h00000013, 0, 32'h1c000504, 0, 0, 0, 0},
    '{NONE,    16'h0000,    0, 0, 32'h1c000508, 0, 0, 0, 60},
    '{CSRRD,   `CSR_ERA,    0, 0, 32'h1c00050c, 0, 0, 0, 0},
    '{CSRWR,   `CSR_TCFG,   32'h00000000, 0, 32'h1c000510, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ESTAT,  0, 0, 32'h1c000514, 0, 0, 0, 0},
    '{CSRWR,   `CSR_TICLR,  32'h00000001, 0, 32'h1c000518, 0, 0, 0, 0},
    '{CSRRD,   `CSR_ESTAT,  0, 0, 32'h1c00051c, 0, 0, 0, 0},
    '{CSRRD,   `CSR_TCFG,   0, 0, 32'h1c000520, 0, 0, 0, 0}
};

`endif

//--- tests/csr_tb.sv
`default_nettype none
`include "csr_defs.svh"

module csr_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        csr_op_e     op;
        logic [15:0] arg;
        logic [31:0] din;
        logic [31:0] mask;
        logic [31:0] pc;
        logic [31:0] badv;
        logic [7:0]  hw_int;
        logic        ipi;
        logic [15:0] wait_cyc;
    } vec_t;

    `include "csr_vectors.svh"

    logic                  clk;
    logic                  rstn;
    csr_req_t              req;
    logic                  stall;
    logic                  flush_in;
    logic [`CSR_HWI_N-1:0] hw_int;
    logic                  ipi;
    csr_resp_t             resp;

    integer seed;
    int     value_errs = 0;
    int     other_errs = 0;
    int     cycles = 0;
    int     cycle_limit = 100000;
    int     cur_row = 0;

    // reference model of the architectural state
    logic [8:0]  crmd_m;
    logic [2:0]  prmd_m;
    logic [12:0] lie_m;
    logic [1:0]  is_m;
    logic [5:0]  ecode_m;
    logic [8:0]  esub_m;
    logic [31:0] era_m;
    logic [31:0] badv_m;
    logic [31:0] eentry_m;
    logic [31:0] save_m [4];
    logic [31:0] tid_m;
    logic [31:0] tcfg_m;
    logic        ti_m;

    csr_top DUT (
        .clk(clk), .rstn(rstn), .req(req), .stall(stall), .flush_in(flush_in),
        .hw_int(hw_int), .ipi(ipi), .resp(resp)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] predict_read(input logic [13:0] num,
                                                 input logic [7:0] hw, input logic ip);
        logic [31:0] v;
        v = '0;
        case (num)
            `CSR_CRMD:   v = {23'b0, crmd_m};
            `CSR_PRMD:   v = {29'b0, prmd_m};
            `CSR_ECFG:   v = {19'b0, lie_m};
            `CSR_ESTAT:  v = {1'b0, esub_m, ecode_m, 3'b0, ip, ti_m, 1'b0, hw, is_m};
            `CSR_ERA:    v = era_m;
            `CSR_BADV:   v = badv_m;
            `CSR_EENTRY: v = eentry_m;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                v = save_m[num[1:0]];
            `CSR_TID:    v = tid_m;
            `CSR_TCFG:   v = tcfg_m;
            default:     v = '0;
        endcase
        return v;
    endfunction

    task automatic apply_write(input logic [13:0] num, input logic [31:0] v);
        case (num)
            `CSR_CRMD:
            begin
                crmd_m[2:0] = v[2:0];
                crmd_m[8:5] = v[8:5];
                if (v[4] != v[3])
                    crmd_m[4:3] = v[4:3];
            end
            `CSR_PRMD:   prmd_m = v[2:0];
            `CSR_ECFG:   lie_m = v[12:0] & 13'h1bff;
            `CSR_ESTAT:  is_m = v[1:0];
            `CSR_ERA:    era_m = v;
            `CSR_BADV:   badv_m = v;
            `CSR_EENTRY: eentry_m = v & 32'hffffffc0;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                save_m[num[1:0]] = v;
            `CSR_TID:    tid_m = v;
            `CSR_TCFG:   tcfg_m = v;
            `CSR_TICLR:
                if (v[0])
                    ti_m = 1'b0;
            default:
                ;
        endcase
    endtask

    task automatic enter_trap(input logic [5:0] ecode, input logic [8:0] esub,
                              input logic [31:0] pc, input logic [31:0] bv);
        prmd_m = crmd_m[2:0];
        crmd_m[2:0] = 3'b0;
        era_m = pc;
        ecode_m = ecode;
        esub_m = esub;
        badv_m = bv;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want)
        begin
            $display("ERR %s got %h expected %h (row %0d)", name, got, want, cur_row);
            value_errs++;
        end
    endtask

    task automatic check_response(input csr_resp_t want);
        compare_value("resp.flush", resp.flush, want.flush);
        compare_value("resp.excp_flush", resp.excp_flush, want.excp_flush);
        compare_value("resp.ertn_flush", resp.ertn_flush, want.ertn_flush);
        compare_value("resp.rdata", resp.rdata, want.rdata);
        if (want.flush)
            compare_value("resp.target_pc", resp.target_pc, want.target_pc);
    endtask

    task automatic run_row(input vec_t v);
        logic [31:0] din;
        logic [31:0] old;
        logic [13:0] num;
        logic [11:0] lines;
        logic        take_int;
        csr_resp_t   want;
        num = v.arg[13:0];
        din = v.din;
        if ((v.op == CSRWR && num >= `CSR_SAVE0 && num <= `CSR_SAVE3) || v.op == CSRXCHG)
            din = $random(seed);
        // ipi, timer, hardware lines, software bits against LIE without bit 10
        lines = {v.ipi, ti_m, v.hw_int, is_m};
        take_int = crmd_m[2] && |(lines & {lie_m[12:11], lie_m[9:0]});
        want = '0;
        if (take_int)
        begin
            want.flush = 1'b1;
            want.excp_flush = 1'b1;
            want.target_pc = eentry_m;
            enter_trap(6'h00, 9'h000, v.pc, v.badv);
        end
        else
        begin
            case (v.op)
                CSRRD:
                    want.rdata = predict_read(num, v.hw_int, v.ipi);
                CSRWR, CSRXCHG:
                begin
                    old = predict_read(num, v.hw_int, v.ipi);
                    want.flush = 1'b1;
                    want.target_pc = v.pc + 32'd4;
                    want.rdata = old;
                    if (v.op == CSRXCHG)
                        apply_write(num, (old & ~v.mask) | (din & v.mask));
                    else
                        apply_write(num, din);
                end
                ERTN:
                begin
                    want.flush = 1'b1;
                    want.ertn_flush = 1'b1;
                    want.target_pc = era_m;
                    crmd_m[2:0] = prmd_m;
                end
                EXCP:
                begin
                    want.flush = 1'b1;
                    want.excp_flush = 1'b1;
                    want.target_pc = eentry_m;
                    // ADEF reports the fetch pc as the bad address
                    if (v.arg[5:0] == 6'h08 && v.arg[14:6] == 9'h000)
                        enter_trap(v.arg[5:0], v.arg[14:6], v.pc, v.pc);
                    else
                        enter_trap(v.arg[5:0], v.arg[14:6], v.pc, v.badv);
                end
                default:
                    ;
            endcase
        end
        @(posedge clk);
        #2;
        req = '0;
        req.valid = 1'b1;
        req.op = v.op;
        req.arg.csr_num = v.arg;
        req.din = din;
        req.mask = v.mask;
        req.pc = v.pc;
        req.badv = v.badv;
        hw_int = v.hw_int;
        ipi = v.ipi;
        @(posedge clk);
        #2;
        req.valid = 1'b0;
        @(negedge clk);
        check_response(want);
        @(posedge clk);
    endtask

    // keep a valid request up until the timer interrupt is taken
    task automatic wait_for_timer(input vec_t v);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        @(posedge clk);
        #2;
        req = '0;
        req.valid = 1'b1;
        req.op = NONE;
        req.pc = v.pc;
        req.badv = v.badv;
        hw_int = v.hw_int;
        ipi = v.ipi;
        while (!seen && n < v.wait_cyc)
        begin
            @(negedge clk);
            if (resp.excp_flush)
            begin
                seen = 1'b1;
                compare_value("resp.flush", resp.flush, 32'd1);
                compare_value("resp.target_pc", resp.target_pc, eentry_m);
            end
            else
            begin
                n++;
            end
        end
        @(posedge clk);
        #2;
        req.valid = 1'b0;
        if (seen)
        begin
            ti_m = 1'b1;
            enter_trap(6'h00, 9'h000, v.pc, v.badv);
        end
        else
        begin
            $display("timer interrupt never arrived within %0d cycles (row %0d)",
                     v.wait_cyc, cur_row);
            other_errs++;
        end
    endtask

    initial
    begin
        int waits;
        waits = 0;
        seed = 32'h99a0f8d6;
        for (int i = 0; i < NUM_ROWS; i++)
            waits += rows[i].wait_cyc;
        cycle_limit = NUM_ROWS * 3 + waits + 50;
        clk = 1'b0;
        rstn = 1'b0;
        req = '0;
        stall = 1'b0;
        flush_in = 1'b0;
        hw_int = '0;
        ipi = 1'b0;
        crmd_m = `CSR_CRMD_RST;
        prmd_m = '0;
        lie_m = '0;
        is_m = '0;
        ecode_m = '0;
        esub_m = '0;
        era_m = '0;
        badv_m = '0;
        eentry_m = '0;
        for (int i = 0; i < 4; i++)
            save_m[i] = '0;
        tid_m = '0;
        tcfg_m = '0;
        ti_m = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            cur_row = i;
            if (rows[i].wait_cyc != 0)
                wait_for_timer(rows[i]);
            else
                run_row(rows[i]);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/csr_top.sv
`default_nettype none
`include "csr_defs.svh"

module csr_top
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_req_t              req,
    input  logic                  stall,
    input  logic                  flush_in,
    input  logic [`CSR_HWI_N-1:0] hw_int,
    input  logic                  ipi,
    output csr_resp_t             resp
);

    logic [`CSR_NUM_W-1:0] rd_num;
    logic [`CSR_XLEN-1:0]  rd_data;
    logic                  int_pending;
    logic [`CSR_XLEN-1:0]  era;
    logic [`CSR_XLEN-1:0]  eentry;
    csr_commit_t           commit;
    logic                  tcfg_we;
    logic                  ticlr;
    logic [`CSR_XLEN-1:0]  wdata;
    logic [`CSR_XLEN-1:0]  tcfg;
    logic [`CSR_XLEN-1:0]  tval;
    logic                  ti;

    csr_issue u_issue (
        .clk(clk), .rstn(rstn), .req(req), .stall(stall), .flush_in(flush_in),
        .rd_num(rd_num), .rd_data(rd_data), .int_pending(int_pending),
        .era(era), .eentry(eentry), .resp(resp), .commit(commit)
    );

    csr_file u_file (
        .clk(clk), .rstn(rstn), .rd_num(rd_num), .rd_data(rd_data), .commit(commit),
        .hw_int(hw_int), .ipi(ipi), .tcfg(tcfg), .tval(tval), .ti(ti),
        .tcfg_we(tcfg_we), .ticlr(ticlr), .wdata(wdata),
        .int_pending(int_pending), .era(era), .eentry(eentry)
    );

    csr_timer #(.timer_width(`CSR_XLEN)) u_timer (
        .clk(clk), .rstn(rstn), .tcfg_we(tcfg_we), .ticlr(ticlr), .wdata(wdata),
        .tcfg(tcfg), .tval(tval), .ti(ti)
    );

endmodule

`default_nettype wire

//--- hdl/csr_timer.sv
`default_nettype none
`include "csr_defs.svh"

module csr_timer #(
    parameter int timer_width = 32
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       tcfg_we,
    input  logic                       ticlr,
    input  logic [`CSR_XLEN-1:0]       wdata,
    output logic [timer_width-1:0]     tcfg,
    output logic [timer_width-1:0]     tval,
    output logic                       ti
);

    logic en_q;
    logic en;
    logic periodic;

    assign en = tcfg[0];
    assign periodic = tcfg[1];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            en_q <= 1'b0;
            ti <= 1'b0;
        end
        else
        begin
            en_q <= en;
            if (tcfg_we)
                tcfg <= wdata[timer_width-1:0];

            // clear wins over a new expiry
            if (ticlr && wdata[0])
                ti <= 1'b0;
            else if (tval == '0 && en && en_q)
                ti <= 1'b1;

            if ((en && !en_q) || (en && periodic && tval == '0))
                tval <= {tcfg[timer_width-1:2], 2'b0};
            else if (!en && en_q)
                tval <= '0;
            else if (en && tval != '1)
                tval <= tval - 1'b1;
        end
    end

    a_ti_needs_en: assert property (@(posedge clk) disable iff (!rstn)
        $rose(ti) |-> $past(en));

endmodule

`default_nettype wire

//--- hdl/csr_file.sv
`default_nettype none
`include "csr_defs.svh"

module csr_file
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [`CSR_NUM_W-1:0] rd_num,
    output logic [`CSR_XLEN-1:0]  rd_data,
    input  csr_commit_t           commit,
    input  logic [`CSR_HWI_N-1:0] hw_int,
    input  logic                  ipi,
    input  logic [`CSR_XLEN-1:0]  tcfg,
    input  logic [`CSR_XLEN-1:0]  tval,
    input  logic                  ti,
    output logic                  tcfg_we,
    output logic                  ticlr,
    output logic [`CSR_XLEN-1:0]  wdata,
    output logic                  int_pending,
    output logic [`CSR_XLEN-1:0]  era,
    output logic [`CSR_XLEN-1:0]  eentry
);

    logic [8:0]             crmd;
    logic [2:0]             prmd;
    logic [12:0]            lie;
    logic [1:0]             estat_is;
    logic [5:0]             estat_ecode;
    logic [8:0]             estat_esub;
    logic [`CSR_XLEN-1:0]   era_q;
    logic [`CSR_XLEN-1:0]   badv;
    logic [`CSR_XLEN-1:6]   eentry_q;
    logic [`CSR_XLEN-1:0]   save [4];
    logic [`CSR_XLEN-1:0]   tid;
    logic [`CSR_HWI_N+3:0]  int_lines;
    logic                   is_write;

    assign era = era_q;
    assign eentry = {eentry_q, 6'b0};

    // ipi, timer, hardware lines, software bits
    assign int_lines = {ipi, ti, hw_int, estat_is};
    assign int_pending = crmd[2] && |(int_lines & {lie[12:11], lie[9:0]});

    assign is_write = (commit.kind == CMT_WRITE);
    assign tcfg_we = is_write && (commit.csr_num == `CSR_TCFG);
    assign ticlr = is_write && (commit.csr_num == `CSR_TICLR);
    assign wdata = commit.wdata;

    always_comb
    begin
        case (rd_num)
            `CSR_CRMD:   rd_data = {23'b0, crmd};
            `CSR_PRMD:   rd_data = {29'b0, prmd};
            `CSR_ECFG:   rd_data = {19'b0, lie};
            `CSR_ESTAT:
                rd_data = {1'b0, estat_esub, estat_ecode, 3'b0, ipi, ti, 1'b0, hw_int, estat_is};
            `CSR_ERA:    rd_data = era_q;
            `CSR_BADV:   rd_data = badv;
            `CSR_EENTRY: rd_data = eentry;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                rd_data = save[rd_num[1:0]];
            `CSR_TID:    rd_data = tid;
            `CSR_TCFG:   rd_data = tcfg;
            `CSR_TVAL:   rd_data = tval;
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd <= `CSR_CRMD_RST;
            prmd <= '0;
            lie <= '0;
            estat_is <= '0;
            estat_ecode <= '0;
            estat_esub <= '0;
            era_q <= '0;
            badv <= '0;
            eentry_q <= '0;
            for (int i = 0; i < 4; i++)
                save[i] <= '0;
            tid <= '0;
        end
        else
        begin
            case (commit.kind)
                CMT_WRITE:
                begin
                    case (commit.csr_num)
                        `CSR_CRMD:
                        begin
                            crmd[2:0] <= commit.wdata[2:0];
                            crmd[8:5] <= commit.wdata[8:5];
                            // da and pg must stay one-hot
                            if (commit.wdata[4] ^ commit.wdata[3])
                                crmd[4:3] <= commit.wdata[4:3];
                        end
                        `CSR_PRMD:   prmd <= commit.wdata[2:0];
                        `CSR_ECFG:   lie <= {commit.wdata[12:11], 1'b0, commit.wdata[9:0]};
                        `CSR_ESTAT:  estat_is <= commit.wdata[1:0];
                        `CSR_ERA:    era_q <= commit.wdata;
                        `CSR_BADV:   badv <= commit.wdata;
                        `CSR_EENTRY: eentry_q <= commit.wdata[`CSR_XLEN-1:6];
                        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                            save[commit.csr_num[1:0]] <= commit.wdata;
                        `CSR_TID:    tid <= commit.wdata;
                        default:
                            ;
                    endcase
                end
                CMT_TRAP:
                begin
                    prmd <= crmd[2:0];
                    crmd[2:0] <= 3'b0;
                    era_q <= commit.pc;
                    estat_ecode <= commit.ecode;
                    estat_esub <= commit.esubcode;
                    badv <= commit.badv;
                end
                CMT_RETURN:
                    crmd[2:0] <= prmd;
                default:
                    ;
            endcase
        end
    end

    a_commit_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(commit.kind));

endmodule

`default_nettype wire

//--- hdl/csr_issue.sv
`default_nettype none
`include "csr_defs.svh"

module csr_issue
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  csr_req_t              req,
    input  logic                  stall,
    input  logic                  flush_in,
    output logic [`CSR_NUM_W-1:0] rd_num,
    input  logic [`CSR_XLEN-1:0]  rd_data,
    input  logic                  int_pending,
    input  logic [`CSR_XLEN-1:0]  era,
    input  logic [`CSR_XLEN-1:0]  eentry,
    output csr_resp_t             resp,
    output csr_commit_t           commit
);

    logic                 accept;
    logic                 take_int;
    logic [`CSR_XLEN-1:0] wmask;
    csr_resp_t            resp_d;
    csr_commit_t          commit_d;

    assign rd_num = req.arg.csr_num[`CSR_NUM_W-1:0];
    assign accept = req.valid && !stall && !flush_in;
    // staged trap has not cleared CRMD.IE yet
    assign take_int = int_pending && req.valid && (commit.kind != CMT_TRAP);
    // plain write behaves as an all-ones mask
    assign wmask = (req.op == CSRXCHG) ? req.mask : '1;

    always_comb
    begin
        resp_d = '0;
        commit_d = '0;
        commit_d.csr_num = rd_num;
        commit_d.pc = req.pc;
        commit_d.badv = req.badv;
        commit_d.wdata = (rd_data & ~wmask) | (req.din & wmask);
        if (take_int)
        begin
            resp_d.flush = 1'b1;
            resp_d.excp_flush = 1'b1;
            resp_d.target_pc = eentry;
            commit_d.kind = CMT_TRAP;
            commit_d.ecode = `CSR_ECODE_INT;
            commit_d.esubcode = '0;
        end
        else if (accept)
        begin
            case (req.op)
                CSRRD:
                begin
                    resp_d.rdata = rd_data;
                end
                CSRWR, CSRXCHG:
                begin
                    resp_d.flush = 1'b1;
                    resp_d.target_pc = req.pc + `CSR_XLEN'd4;
                    resp_d.rdata = rd_data;
                    commit_d.kind = CMT_WRITE;
                end
                ERTN:
                begin
                    resp_d.flush = 1'b1;
                    resp_d.ertn_flush = 1'b1;
                    resp_d.target_pc = era;
                    commit_d.kind = CMT_RETURN;
                end
                EXCP:
                begin
                    resp_d.flush = 1'b1;
                    resp_d.excp_flush = 1'b1;
                    resp_d.target_pc = eentry;
                    commit_d.kind = CMT_TRAP;
                    commit_d.ecode = req.arg.excp.ecode;
                    commit_d.esubcode = req.arg.excp.esubcode;
                    // fetch address error reports the pc itself
                    if (req.arg.excp.ecode == `CSR_ECODE_ADE &&
                        req.arg.excp.esubcode == `CSR_ESUB_ADEF)
                        commit_d.badv = req.pc;
                end
                default:
                    ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            resp <= '0;
            commit.kind <= CMT_NONE;
        end
        else
        begin
            resp <= resp_d;
            commit.kind <= commit_d.kind;
        end
    end

    always_ff @(posedge clk)
    begin
        commit.csr_num <= commit_d.csr_num;
        commit.wdata <= commit_d.wdata;
        commit.pc <= commit_d.pc;
        commit.ecode <= commit_d.ecode;
        commit.esubcode <= commit_d.esubcode;
        commit.badv <= commit_d.badv;
    end

    a_one_flush_kind: assert property (@(posedge clk) disable iff (!rstn)
        !(resp.excp_flush && resp.ertn_flush));

    a_kind_implies_flush: assert property (@(posedge clk) disable iff (!rstn)
        (resp.excp_flush || resp.ertn_flush) |-> resp.flush);

endmodule

`default_nettype wire

//--- hdl/csr_pkg.sv
`default_nettype none
`include "csr_defs.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        NONE,
        CSRRD,
        CSRWR,
        CSRXCHG,
        ERTN,
        EXCP
    } csr_op_e;

    typedef enum logic [1:0] {
        CMT_NONE,
        CMT_WRITE,
        CMT_TRAP,
        CMT_RETURN
    } csr_kind_e;

    typedef struct packed {
        logic       pad;
        logic [8:0] esubcode;
        logic [5:0] ecode;
    } csr_excp_t;

    // csr number for csr ops, exception codes for EXCP
    typedef union packed {
        logic [15:0] csr_num;
        csr_excp_t   excp;
    } csr_arg_u;

    typedef struct packed {
        logic                 valid;
        csr_op_e              op;
        csr_arg_u             arg;
        logic [`CSR_XLEN-1:0] din;
        logic [`CSR_XLEN-1:0] mask;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] badv;
    } csr_req_t;

    typedef struct packed {
        logic                 flush;
        logic                 excp_flush;
        logic                 ertn_flush;
        logic [`CSR_XLEN-1:0] target_pc;
        logic [`CSR_XLEN-1:0] rdata;
    } csr_resp_t;

    typedef struct packed {
        csr_kind_e             kind;
        logic [`CSR_NUM_W-1:0] csr_num;
        logic [`CSR_XLEN-1:0]  wdata;
        logic [`CSR_XLEN-1:0]  pc;
        logic [5:0]            ecode;
        logic [8:0]            esubcode;
        logic [`CSR_XLEN-1:0]  badv;
    } csr_commit_t;

endpackage

`default_nettype wire

//--- hdl/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data path and field widths
`define CSR_XLEN 32
`define CSR_NUM_W 14
`define CSR_HWI_N 8

// csr numbers
`define CSR_CRMD 14'h000
`define CSR_PRMD 14'h001
`define CSR_ECFG 14'h004
`define CSR_ESTAT 14'h005
`define CSR_ERA 14'h006
`define CSR_BADV 14'h007
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0 14'h030
`define CSR_SAVE1 14'h031
`define CSR_SAVE2 14'h032
`define CSR_SAVE3 14'h033
`define CSR_TID 14'h040
`define CSR_TCFG 14'h041
`define CSR_TVAL 14'h042
`define CSR_TICLR 14'h044

// exception codes
`define CSR_ECODE_INT 6'h00
`define CSR_ECODE_ADE 6'h08
`define CSR_ESUB_ADEF 9'h000

// da set, everything else clear
`define CSR_CRMD_RST 9'h008

`endif
